// ==== Makefile ====
TOP = cmp_cluster_tb

.PHONY: all lint clean

# build, run, and fail unless the pass line shows up
all:
	verilator --binary --timing --assert --top-module $(TOP) -f cmp_cluster.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | awk '{ print } /^PASS: all tests$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f cmp_cluster.f

clean:
	rm -rf obj_dir

// ==== cmp_cluster.f ====
hw/cmp_pkg.sv
hw/rs_cdb_if.sv
hw/cmp_unit.sv
hw/cmp_rs.sv
hw/cdb_arbiter.sv
hw/cmp_cluster.sv
verif/tb_clock.sv
verif/cmp_cluster_asserts.sv
verif/cmp_cluster_tb.sv

// ==== hw/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           flush_i,
    rs_cdb_if.arbiter      arb,
    output logic           cdb_valid_o,
    output cmp_pkg::tag_t  cdb_tag_o,
    output cmp_pkg::word_t cdb_value_o
);
    import cmp_pkg::*;

    logic [RS_SIZE-1:0] grant;
    rs_idx_t            sel;
    logic               any_done;

    // lowest done index wins
    always_comb begin
        sel      = '0;
        any_done = 1'b0;
        grant    = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (arb.done[i]) begin
                sel      = rs_idx_t'(i);
                any_done = 1'b1;
            end
        end
        // nothing leaves during flush
        if (any_done && !flush_i) begin
            grant[sel] = 1'b1;
        end
    end

    assign arb.grant = grant;

    // bus valid one edge after grant
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cdb_valid_o <= 1'b0;
        end else begin
            cdb_valid_o <= any_done && !flush_i;
        end
    end

    // tag and zero-extended result bit
    always_ff @(posedge clk) begin
        if (any_done) begin
            cdb_tag_o   <= arb.rob_idx[sel];
            cdb_value_o <= {{(XLEN - 1){1'b0}}, arb.result[sel]};
        end
    end

endmodule

// ==== hw/cmp_cluster.sv ====
`timescale 1ns/1ps

module cmp_cluster (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  logic                                     flush_i,
    // issue port
    input  logic                                     issue_req_i,
    output logic                                     issue_ack_o,
    input  cmp_pkg::cmp_op_t                         issue_op_i,
    input  cmp_pkg::tag_t                            issue_rob_idx_i,
    input  logic                                     issue_src1_ready_i,
    input  cmp_pkg::tag_t                            issue_src1_tag_i,
    input  cmp_pkg::word_t                           issue_src1_value_i,
    input  logic                                     issue_src2_ready_i,
    input  cmp_pkg::tag_t                            issue_src2_tag_i,
    input  cmp_pkg::word_t                           issue_src2_value_i,
    // external result buses
    input  logic [cmp_pkg::NUM_CDB_IN-1:0]           cdb_in_valid_i,
    input  cmp_pkg::tag_t [cmp_pkg::NUM_CDB_IN-1:0]  cdb_in_tag_i,
    input  cmp_pkg::word_t [cmp_pkg::NUM_CDB_IN-1:0] cdb_in_value_i,
    // cluster broadcast
    output logic                                     cdb_valid_o,
    output cmp_pkg::tag_t                            cdb_tag_o,
    output cmp_pkg::word_t                           cdb_value_o
);

    // station to arbiter
    rs_cdb_if u_arb_if ();

    cmp_rs u_rs (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .flush_i            (flush_i),
        .issue_req_i        (issue_req_i),
        .issue_ack_o        (issue_ack_o),
        .issue_op_i         (issue_op_i),
        .issue_rob_idx_i    (issue_rob_idx_i),
        .issue_src1_ready_i (issue_src1_ready_i),
        .issue_src1_tag_i   (issue_src1_tag_i),
        .issue_src1_value_i (issue_src1_value_i),
        .issue_src2_ready_i (issue_src2_ready_i),
        .issue_src2_tag_i   (issue_src2_tag_i),
        .issue_src2_value_i (issue_src2_value_i),
        .cdb_in_valid_i     (cdb_in_valid_i),
        .cdb_in_tag_i       (cdb_in_tag_i),
        .cdb_in_value_i     (cdb_in_value_i),
        // own broadcast wakes chained operands
        .own_valid_i        (cdb_valid_o),
        .own_tag_i          (cdb_tag_o),
        .own_value_i        (cdb_value_o),
        .arb                (u_arb_if.station)
    );

    cdb_arbiter u_arbiter (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .arb         (u_arb_if.arbiter),
        .cdb_valid_o (cdb_valid_o),
        .cdb_tag_o   (cdb_tag_o),
        .cdb_value_o (cdb_value_o)
    );

endmodule

// ==== hw/cmp_pkg.sv ====
package cmp_pkg;

    // datapath word
    localparam int XLEN = 32;
    typedef logic [XLEN-1:0] word_t;

    // reorder buffer depth sets the tag width
    localparam int ROB_ENTRIES = 8;
    typedef logic [$clog2(ROB_ENTRIES)-1:0] tag_t;

    // station size
    localparam int RS_SIZE = 4;
    typedef logic [$clog2(RS_SIZE)-1:0] rs_idx_t;

    // external result buses feeding wakeup
    localparam int NUM_CDB_IN = 2;

    // compare opcodes
    typedef logic [2:0] cmp_op_t;

    // branch conditions
    localparam cmp_op_t OP_EQ   = 3'd0;
    localparam cmp_op_t OP_NE   = 3'd1;
    localparam cmp_op_t OP_LT   = 3'd2;
    localparam cmp_op_t OP_GE   = 3'd3;
    localparam cmp_op_t OP_LTU  = 3'd4;
    localparam cmp_op_t OP_GEU  = 3'd5;
    // set-less-than forms of the same orderings
    localparam cmp_op_t OP_SLT  = 3'd6;
    localparam cmp_op_t OP_SLTU = 3'd7;

    // issue handshake states
    // idle waits for req, ack holds until req drops
    typedef enum logic {
        ISSUE_IDLE,
        ISSUE_ACK
    } issue_state_t;

endpackage

// ==== hw/cmp_rs.sv ====
`timescale 1ns/1ps

module cmp_rs (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  logic                                     flush_i,
    // four-phase issue side
    input  logic                                     issue_req_i,
    output logic                                     issue_ack_o,
    input  cmp_pkg::cmp_op_t                         issue_op_i,
    input  cmp_pkg::tag_t                            issue_rob_idx_i,
    input  logic                                     issue_src1_ready_i,
    input  cmp_pkg::tag_t                            issue_src1_tag_i,
    input  cmp_pkg::word_t                           issue_src1_value_i,
    input  logic                                     issue_src2_ready_i,
    input  cmp_pkg::tag_t                            issue_src2_tag_i,
    input  cmp_pkg::word_t                           issue_src2_value_i,
    // external result buses
    input  logic [cmp_pkg::NUM_CDB_IN-1:0]           cdb_in_valid_i,
    input  cmp_pkg::tag_t [cmp_pkg::NUM_CDB_IN-1:0]  cdb_in_tag_i,
    input  cmp_pkg::word_t [cmp_pkg::NUM_CDB_IN-1:0] cdb_in_value_i,
    // own broadcast looped back
    input  logic                                     own_valid_i,
    input  cmp_pkg::tag_t                            own_tag_i,
    input  cmp_pkg::word_t                           own_value_i,
    rs_cdb_if.station                                arb
);
    import cmp_pkg::*;

    // all wakeup sources with the own port on top
    logic [NUM_CDB_IN:0]  src_valid;
    tag_t [NUM_CDB_IN:0]  src_tag;
    word_t [NUM_CDB_IN:0] src_value;

    // per-entry control
    logic [RS_SIZE-1:0] busy_q;
    logic [RS_SIZE-1:0] launched_q;
    logic [RS_SIZE-1:0] start_q;
    logic [RS_SIZE-1:0] s1_rdy_q;
    logic [RS_SIZE-1:0] s2_rdy_q;

    // per-entry payload
    cmp_op_t            op_q [RS_SIZE];
    tag_t [RS_SIZE-1:0] rob_q;
    tag_t               s1_tag_q [RS_SIZE];
    tag_t               s2_tag_q [RS_SIZE];
    word_t              s1_val_q [RS_SIZE];
    word_t              s2_val_q [RS_SIZE];

    // compare unit outputs
    logic [RS_SIZE-1:0] done_w;
    logic [RS_SIZE-1:0] res_w;

    issue_state_t state_q;
    logic         free_any;
    rs_idx_t      free_idx;
    logic         issue_we;

    assign src_valid = {own_valid_i, cdb_in_valid_i};
    assign src_tag   = {own_tag_i, cdb_in_tag_i};
    assign src_value = {own_value_i, cdb_in_value_i};

    // any valid source carrying this tag
    function automatic logic tag_hit(input tag_t tag);
        logic hit;
        hit = 1'b0;
        for (int s = 0; s <= NUM_CDB_IN; s++) begin
            if (src_valid[s] && src_tag[s] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // value from the matching source or the current one
    function automatic word_t tag_value(input tag_t tag, input word_t cur);
        word_t val;
        val = cur;
        for (int s = 0; s <= NUM_CDB_IN; s++) begin
            if (src_valid[s] && src_tag[s] == tag) begin
                val = src_value[s];
            end
        end
        return val;
    endfunction

    // lowest free slot
    always_comb begin
        free_any = 1'b0;
        free_idx = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                free_any = 1'b1;
                free_idx = rs_idx_t'(i);
            end
        end
    end

    // entry written on the edge that raises ack
    assign issue_we    = (state_q == ISSUE_IDLE) && issue_req_i && free_any && !flush_i;
    assign issue_ack_o = (state_q == ISSUE_ACK);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ISSUE_IDLE;
        end else if (flush_i) begin
            state_q <= ISSUE_IDLE;
        end else begin
            case (state_q)
                ISSUE_IDLE: if (issue_we) state_q <= ISSUE_ACK;
                // ack drops once req is seen low
                ISSUE_ACK:  if (!issue_req_i) state_q <= ISSUE_IDLE;
                default:    state_q <= ISSUE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q     <= '0;
            launched_q <= '0;
            start_q    <= '0;
            s1_rdy_q   <= '0;
            s2_rdy_q   <= '0;
        end else if (flush_i) begin
            busy_q     <= '0;
            launched_q <= '0;
            start_q    <= '0;
            s1_rdy_q   <= '0;
            s2_rdy_q   <= '0;
        end else begin
            for (int i = 0; i < RS_SIZE; i++) begin
                start_q[i] <= 1'b0;
                if (arb.grant[i]) begin
                    // result leaves on the bus and the slot is free again
                    busy_q[i]     <= 1'b0;
                    launched_q[i] <= 1'b0;
                    s1_rdy_q[i]   <= 1'b0;
                    s2_rdy_q[i]   <= 1'b0;
                end else if (busy_q[i]) begin
                    // tag match wakes a pending operand
                    if (!s1_rdy_q[i] && tag_hit(s1_tag_q[i])) begin
                        s1_rdy_q[i] <= 1'b1;
                    end
                    if (!s2_rdy_q[i] && tag_hit(s2_tag_q[i])) begin
                        s2_rdy_q[i] <= 1'b1;
                    end
                    // single start pulse per occupancy
                    if (s1_rdy_q[i] && s2_rdy_q[i] && !launched_q[i]) begin
                        start_q[i]    <= 1'b1;
                        launched_q[i] <= 1'b1;
                    end
                end else if (issue_we && free_idx == rs_idx_t'(i)) begin
                    busy_q[i]   <= 1'b1;
                    // same-cycle broadcast counts as ready
                    s1_rdy_q[i] <= issue_src1_ready_i || tag_hit(issue_src1_tag_i);
                    s2_rdy_q[i] <= issue_src2_ready_i || tag_hit(issue_src2_tag_i);
                end
            end
        end
    end

    // operand and tag storage
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            if (issue_we && free_idx == rs_idx_t'(i)) begin
                op_q[i]     <= issue_op_i;
                rob_q[i]    <= issue_rob_idx_i;
                s1_tag_q[i] <= issue_src1_tag_i;
                s2_tag_q[i] <= issue_src2_tag_i;
                s1_val_q[i] <= issue_src1_ready_i
                             ? issue_src1_value_i
                             : tag_value(issue_src1_tag_i, issue_src1_value_i);
                s2_val_q[i] <= issue_src2_ready_i
                             ? issue_src2_value_i
                             : tag_value(issue_src2_tag_i, issue_src2_value_i);
            end else if (busy_q[i]) begin
                // pending operands pick up bus values
                if (!s1_rdy_q[i]) begin
                    s1_val_q[i] <= tag_value(s1_tag_q[i], s1_val_q[i]);
                end
                if (!s2_rdy_q[i]) begin
                    s2_val_q[i] <= tag_value(s2_tag_q[i], s2_val_q[i]);
                end
            end
        end
    end

    // one compare unit per slot
    for (genvar i = 0; i < RS_SIZE; i++) begin : g_cmp
        cmp_unit u_cmp (
            .clk      (clk),
            .rst_n_i  (rst_n_i),
            .start_i  (start_q[i]),
            .op_i     (op_q[i]),
            .a_i      (s1_val_q[i]),
            .b_i      (s2_val_q[i]),
            .clear_i  (arb.grant[i] | flush_i),
            .done_o   (done_w[i]),
            .result_o (res_w[i])
        );
    end

    assign arb.done    = done_w;
    assign arb.result  = res_w;
    assign arb.rob_idx = rob_q;

endmodule

// ==== hw/cmp_unit.sv ====
`timescale 1ns/1ps

module cmp_unit (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             start_i,
    input  cmp_pkg::cmp_op_t op_i,
    input  cmp_pkg::word_t   a_i,
    input  cmp_pkg::word_t   b_i,
    input  logic             clear_i,
    output logic             done_o,
    output logic             result_o
);
    import cmp_pkg::*;

    logic cmp_res;
    logic lt_s;
    logic lt_u;

    // both orderings computed once, shared by the opcodes
    assign lt_s = $signed(a_i) < $signed(b_i);
    assign lt_u = a_i < b_i;

    always_comb begin
        case (op_i)
            OP_EQ:   cmp_res = (a_i == b_i);
            OP_NE:   cmp_res = (a_i != b_i);
            OP_LT:   cmp_res = lt_s;
            OP_GE:   cmp_res = !lt_s;
            OP_LTU:  cmp_res = lt_u;
            OP_GEU:  cmp_res = !lt_u;
            OP_SLT:  cmp_res = lt_s;
            OP_SLTU: cmp_res = lt_u;
            default: cmp_res = 1'b0;
        endcase
    end

    // done holds until the entry leaves the station
    // clear wins over a same-cycle start
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_o <= 1'b0;
        end else if (clear_i) begin
            done_o <= 1'b0;
        end else if (start_i) begin
            done_o <= 1'b1;
        end
    end

    // result captured once per start
    always_ff @(posedge clk) begin
        if (start_i) begin
            result_o <= cmp_res;
        end
    end

endmodule

// ==== hw/rs_cdb_if.sv ====
`timescale 1ns/1ps

interface rs_cdb_if;
    import cmp_pkg::*;

    // finished entries waiting for the bus
    logic [RS_SIZE-1:0] done;
    // compare outcome per entry
    logic [RS_SIZE-1:0] result;
    // destination rob slot per entry
    tag_t [RS_SIZE-1:0] rob_idx;
    // one-hot winner this cycle
    logic [RS_SIZE-1:0] grant;

    // station side
    modport station (
        output done,
        output result,
        output rob_idx,
        input  grant
    );

    // arbiter side
    modport arbiter (
        input  done,
        input  result,
        input  rob_idx,
        output grant
    );

endinterface

// ==== verif/cmp_cluster_asserts.sv ====
`timescale 1ns/1ps

module cmp_cluster_asserts (
    input logic                        clk,
    input logic                        rst_n_i,
    input logic                        req_i,
    input logic                        ack_i,
    input logic [cmp_pkg::RS_SIZE-1:0] grant_i
);

    // ack only ever answers a pending request
    ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $rose(ack_i) |-> $past(req_i)
    ) else $error("issue ack rose without a request");

    // arbiter frees at most one entry per cycle
    grant_onehot: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $onehot0(grant_i)
    ) else $error("more than one grant bit high: %b", grant_i);

endmodule

// attached to every station instance
bind cmp_rs cmp_cluster_asserts u_asserts (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (issue_req_i),
    .ack_i   (issue_ack_o),
    .grant_i (arb.grant)
);

// ==== verif/cmp_cluster_tb.sv ====
`timescale 1ns/1ps

module cmp_cluster_tb;
    import cmp_pkg::*;

    localparam int PERIOD_NS       = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int RANDOM_OPS      = 20;
    localparam int ACK_LIMIT       = 50;
    localparam int DRAIN_LIMIT     = 100;

    logic                   clk;
    logic                   rst_n_i;
    logic                   flush_i;
    logic                   issue_req_i;
    logic                   issue_ack_o;
    cmp_op_t                issue_op_i;
    tag_t                   issue_rob_idx_i;
    logic                   issue_src1_ready_i;
    tag_t                   issue_src1_tag_i;
    word_t                  issue_src1_value_i;
    logic                   issue_src2_ready_i;
    tag_t                   issue_src2_tag_i;
    word_t                  issue_src2_value_i;
    logic [NUM_CDB_IN-1:0]  cdb_in_valid_i;
    tag_t [NUM_CDB_IN-1:0]  cdb_in_tag_i;
    word_t [NUM_CDB_IN-1:0] cdb_in_value_i;
    logic                   cdb_valid_o;
    tag_t                   cdb_tag_o;
    word_t                  cdb_value_o;

    // scoreboard per destination tag
    // expected word, plus the tags each operand still waits on
    logic  inflight [ROB_ENTRIES];
    word_t exp_val  [ROB_ENTRIES];
    logic  wait1    [ROB_ENTRIES];
    logic  wait2    [ROB_ENTRIES];
    tag_t  wtag1    [ROB_ENTRIES];
    tag_t  wtag2    [ROB_ENTRIES];

    int seed;
    int errors;
    int checks;
    int tests_run;
    int mark;

    tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n_i)
    );

    cmp_cluster dut_i (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .flush_i            (flush_i),
        .issue_req_i        (issue_req_i),
        .issue_ack_o        (issue_ack_o),
        .issue_op_i         (issue_op_i),
        .issue_rob_idx_i    (issue_rob_idx_i),
        .issue_src1_ready_i (issue_src1_ready_i),
        .issue_src1_tag_i   (issue_src1_tag_i),
        .issue_src1_value_i (issue_src1_value_i),
        .issue_src2_ready_i (issue_src2_ready_i),
        .issue_src2_tag_i   (issue_src2_tag_i),
        .issue_src2_value_i (issue_src2_value_i),
        .cdb_in_valid_i     (cdb_in_valid_i),
        .cdb_in_tag_i       (cdb_in_tag_i),
        .cdb_in_value_i     (cdb_in_value_i),
        .cdb_valid_o        (cdb_valid_o),
        .cdb_tag_o          (cdb_tag_o),
        .cdb_value_o        (cdb_value_o)
    );

    // RV32I branch and set-less-than semantics, result as 0/1 word
    function automatic word_t ref_cmp(input cmp_op_t op, input word_t a, input word_t b);
        logic r;
        case (op)
            OP_EQ:           r = (a == b);
            OP_NE:           r = (a != b);
            OP_LT, OP_SLT:   r = ($signed(a) < $signed(b));
            OP_GE:           r = ($signed(a) >= $signed(b));
            OP_LTU, OP_SLTU: r = (a < b);
            OP_GEU:          r = (a >= b);
            default:         r = 1'b0;
        endcase
        return word_t'(r);
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    // four-phase issue, scoreboard filled before req rises
    task automatic issue_op(input cmp_op_t op, input tag_t dest,
                            input logic r1, input tag_t t1, input word_t v1,
                            input logic r2, input tag_t t2, input word_t v2);
        int waited;
        waited = 0;
        // a tag is reused only after its broadcast
        while (inflight[dest]) @(negedge clk);
        @(posedge clk);
        #1;
        issue_req_i        = 1'b1;
        issue_op_i         = op;
        issue_rob_idx_i    = dest;
        issue_src1_ready_i = r1;
        issue_src1_tag_i   = t1;
        // pending operands carry junk that the wakeup must replace
        issue_src1_value_i = r1 ? v1 : $random(seed);
        issue_src2_ready_i = r2;
        issue_src2_tag_i   = t2;
        issue_src2_value_i = r2 ? v2 : $random(seed);
        exp_val[dest]  = ref_cmp(op, v1, v2);
        wait1[dest]    = !r1;
        wait2[dest]    = !r2;
        wtag1[dest]    = t1;
        wtag2[dest]    = t2;
        inflight[dest] = 1'b1;
        @(negedge clk);
        while (!issue_ack_o && waited < ACK_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!issue_ack_o) begin
            report_error($sformatf("issue of tag %0d was never acknowledged", dest));
            inflight[dest] = 1'b0;
        end
        @(posedge clk);
        #1;
        issue_req_i = 1'b0;
        @(negedge clk);
        while (issue_ack_o) @(negedge clk);
    endtask

    // one-cycle word on an external CDB port
    task automatic wake(input int port, input tag_t tag, input word_t value);
        @(posedge clk);
        #1;
        cdb_in_valid_i[port] = 1'b1;
        cdb_in_tag_i[port]   = tag;
        cdb_in_value_i[port] = value;
        for (int t = 0; t < ROB_ENTRIES; t++) begin
            if (wait1[t] && wtag1[t] == tag) wait1[t] = 1'b0;
            if (wait2[t] && wtag2[t] == tag) wait2[t] = 1'b0;
        end
        @(posedge clk);
        #1;
        cdb_in_valid_i[port] = 1'b0;
    endtask

    task automatic flush_cycle();
        @(posedge clk);
        #1;
        flush_i = 1'b1;
        // nothing issued so far may broadcast any more
        for (int t = 0; t < ROB_ENTRIES; t++) begin
            inflight[t] = 1'b0;
            wait1[t]    = 1'b0;
            wait2[t]    = 1'b0;
        end
        @(posedge clk);
        #1;
        flush_i = 1'b0;
    endtask

    // wait for every issued tag, then report the test
    task automatic finish_test(input string name);
        int  waited;
        logic busy;
        waited = 0;
        busy   = 1'b1;
        while (busy && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
            busy = 1'b0;
            for (int t = 0; t < ROB_ENTRIES; t++) busy = busy | inflight[t];
        end
        for (int t = 0; t < ROB_ENTRIES; t++) begin
            if (inflight[t]) begin
                report_error($sformatf("tag %0d was never broadcast", t));
                inflight[t] = 1'b0;
            end
        end
        // late duplicates still get caught here
        repeat (4) @(negedge clk);
        tests_run++;
        $display("test %0d %s done, %0d errors", tests_run, name, errors - mark);
        mark = errors;
    endtask

    task automatic test_ready();
        word_t a_vals [3] = '{32'd5, 32'h8000_0000, 32'd0};
        word_t b_vals [3] = '{32'd5, 32'd1, 32'hffff_ffff};
        int    n;
        n = 0;
        for (int op = 0; op < 8; op++) begin
            for (int k = 0; k < 3; k++) begin
                issue_op(cmp_op_t'(op), tag_t'(n % ROB_ENTRIES),
                         1'b1, '0, a_vals[k], 1'b1, '0, b_vals[k]);
                n++;
            end
        end
        finish_test("ready");
    endtask

    task automatic test_pending();
        // one tagged operand, then two
        issue_op(OP_LT, 3'd0, 1'b0, 3'd6, 32'hffff_fff0, 1'b1, '0, 32'd3);
        issue_op(OP_GEU, 3'd1, 1'b0, 3'd5, 32'h0000_0010, 1'b0, 3'd7, 32'h8000_0000);
        repeat (6) @(posedge clk);
        // both external ports in the same cycle
        fork
            wake(0, 3'd6, 32'hffff_fff0);
            wake(1, 3'd5, 32'h0000_0010);
        join
        repeat (3) @(posedge clk);
        wake(0, 3'd7, 32'h8000_0000);
        finish_test("pending");
    endtask

    task automatic test_chain();
        // 2 waits on an external tag, 3 on 2, 4 on both 3 and 2
        issue_op(OP_LTU, 3'd2, 1'b0, 3'd6, 32'd3, 1'b1, '0, 32'd10);
        issue_op(OP_EQ, 3'd3, 1'b0, 3'd2, exp_val[2], 1'b1, '0, 32'd1);
        issue_op(OP_GE, 3'd4, 1'b0, 3'd3, exp_val[3], 1'b0, 3'd2, exp_val[2]);
        repeat (4) @(posedge clk);
        wake(1, 3'd6, 32'd3);
        finish_test("chain");
    endtask

    task automatic test_full();
        int acks;
        acks = 0;
        // four entries stuck on tags 4 to 7
        for (int i = 0; i < RS_SIZE; i++) begin
            issue_op(OP_NE, tag_t'(i), 1'b0, tag_t'(i + 4), word_t'(i), 1'b1, '0, 32'd1);
        end
        fork
            issue_op(OP_SLT, 3'd4, 1'b1, '0, 32'h8000_0000, 1'b1, '0, 32'd0);
            begin
                repeat (8) begin
                    @(negedge clk);
                    if (issue_ack_o) acks++;
                end
                if (acks != 0) report_error("issue acknowledged while the station was full");
                wake(0, 3'd4, 32'd0);
            end
        join
        for (int i = 1; i < RS_SIZE; i++) wake(i % 2, tag_t'(i + 4), word_t'(i));
        finish_test("full");
    endtask

    task automatic test_flush();
        for (int i = 0; i < 3; i++) begin
            issue_op(OP_EQ, tag_t'(i), 1'b0, tag_t'(i + 5), 32'd9, 1'b1, '0, 32'd9);
        end
        flush_cycle();
        // wakeups for flushed entries must stay silent
        wake(0, 3'd5, 32'd9);
        wake(1, 3'd6, 32'd9);
        wake(0, 3'd7, 32'd9);
        repeat (8) @(posedge clk);
        // whole station free again
        for (int i = 0; i < RS_SIZE; i++) begin
            issue_op(OP_LTU, tag_t'(i), 1'b0, tag_t'(i + 4), word_t'(i), 1'b1, '0, 32'd2);
        end
        for (int i = 0; i < RS_SIZE; i++) wake(i % 2, tag_t'(i + 4), word_t'(i));
        finish_test("flush");
    endtask

    task automatic test_random();
        logic [31:0] rnd;
        word_t       a;
        word_t       b;
        word_t       ext;
        tag_t        dest;
        tag_t        ext_tag;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            rnd     = $random(seed);
            a       = $random(seed);
            b       = $random(seed);
            ext     = $random(seed);
            // dest 0..3, pending operands wait on dest + 4
            dest    = tag_t'(n % 4);
            ext_tag = tag_t'(n % 4 + 4);
            issue_op(cmp_op_t'(rnd[7:5]), dest, rnd[0], ext_tag, rnd[0] ? a : ext,
                     rnd[1], ext_tag, rnd[1] ? b : ext);
            if (!rnd[0] || !rnd[1]) begin
                repeat (rnd[4:3]) @(posedge clk);
                wake(rnd[2] ? 1 : 0, ext_tag, ext);
            end
        end
        finish_test("random");
    endtask

    // compares every broadcast with the scoreboard
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n_i && cdb_valid_o) begin
                if (!inflight[cdb_tag_o]) begin
                    report_error($sformatf("broadcast of tag %0d not in flight", cdb_tag_o));
                end else if (wait1[cdb_tag_o] || wait2[cdb_tag_o]) begin
                    report_error($sformatf("tag %0d broadcast before its operands", cdb_tag_o));
                    inflight[cdb_tag_o] = 1'b0;
                end else begin
                    check_word($sformatf("cdb_value_o tag %0d", cdb_tag_o),
                               cdb_value_o, exp_val[cdb_tag_o]);
                    inflight[cdb_tag_o] = 1'b0;
                end
                // chained operands resolved by our own broadcast
                for (int t = 0; t < ROB_ENTRIES; t++) begin
                    if (wait1[t] && wtag1[t] == cdb_tag_o) wait1[t] = 1'b0;
                    if (wait2[t] && wtag2[t] == cdb_tag_o) wait2[t] = 1'b0;
                end
            end
        end
    end

    // watchdog sized from the test count
    initial begin
        repeat (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles",
                 RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        seed               = 32'h2204_88af;
        errors             = 0;
        checks             = 0;
        tests_run          = 0;
        mark               = 0;
        flush_i            = 1'b0;
        issue_req_i        = 1'b0;
        issue_op_i         = OP_EQ;
        issue_rob_idx_i    = '0;
        issue_src1_ready_i = 1'b0;
        issue_src1_tag_i   = '0;
        issue_src1_value_i = '0;
        issue_src2_ready_i = 1'b0;
        issue_src2_tag_i   = '0;
        issue_src2_value_i = '0;
        cdb_in_valid_i     = '0;
        cdb_in_tag_i       = '0;
        cdb_in_value_i     = '0;
        for (int t = 0; t < ROB_ENTRIES; t++) begin
            inflight[t] = 1'b0;
            exp_val[t]  = '0;
            wait1[t]    = 1'b0;
            wait2[t]    = 1'b0;
            wtag1[t]    = '0;
            wtag2[t]    = '0;
        end
        @(posedge rst_n_i);
        test_ready();
        test_pending();
        test_chain();
        test_full();
        test_flush();
        test_random();
        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    // free-running clock
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset released just after a rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule
